/* hw/cavlc_settings.svh */
`ifndef CAVLC_SETTINGS_SVH
`define CAVLC_SETTINGS_SVH

// width of one residual coefficient, two's complement
`define CAVLC_COEFF_W 8

// coefficients in one 4x4 block, in zigzag order
`define CAVLC_BLOCK_N 16

// suffix length saturates here, per the adaptive VLC rule
`define CAVLC_MAX_SUFFIX 6

// suffix width that goes with escape prefix 15
`define CAVLC_ESC_SUFFIX_W 12

`endif

/* hw/cavlc_block_pkg.sv */
`include "cavlc_settings.svh"

package cavlc_block_pkg;

    // one signed residual coefficient
    typedef logic signed [`CAVLC_COEFF_W-1:0] coeff_t;

    // a full block, element 0 is the DC position of the zigzag scan
    typedef coeff_t [`CAVLC_BLOCK_N-1:0] coeff_block_t;

    // remaining levels, element 0 is the highest frequency one found
    typedef coeff_t [`CAVLC_BLOCK_N-1:0] level_list_t;

    // t1_signs bit 0 belongs to the first trailing one met in the reverse scan
    typedef struct packed {
        logic [4:0] total_coeff;
        logic [1:0] trailing_ones;
        logic [2:0] t1_signs;
    } block_summary_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DONE
    } scan_state_e;

endpackage

/* hw/cavlc_code_pkg.sv */
`include "cavlc_settings.svh"

package cavlc_code_pkg;

    // prefix counts the zeros in front of the terminating one
    // suffix is right-aligned, only suffix_len bits of it are sent
    typedef struct packed {
        logic [4:0]                       prefix;
        logic [`CAVLC_ESC_SUFFIX_W-1:0]   suffix;
        logic [3:0]                       suffix_len;
    } level_codeword_t;

    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_RUN,
        ENC_FINISH
    } enc_state_e;

endpackage

/* hw/coeff_scanner.sv */
`timescale 1ns/1ps
`include "cavlc_settings.svh"

module coeff_scanner (
    input  logic                            clk,
    input  logic                            enc_rst,
    input  logic                            start_i,
    input  cavlc_block_pkg::coeff_block_t   coeffs_i,
    input  logic                            enc_busy_i,
    output logic                            busy_o,
    output logic                            load_o,
    output cavlc_block_pkg::block_summary_t summary_o,
    output cavlc_block_pkg::level_list_t    levels_o,
    output logic [4:0]                      level_cnt_o
);

    cavlc_block_pkg::scan_state_e state_q;
    logic [3:0]                    idx_q;
    logic                          load_q;
    cavlc_block_pkg::coeff_block_t blk_q;
    cavlc_block_pkg::level_list_t  levels_q;
    logic [4:0]                    total_q;
    logic [1:0]                    t1_q;
    logic [2:0]                    t1_signs_q;
    logic [4:0]                    lvl_cnt_q;
    logic                          big_seen_q;

    cavlc_block_pkg::coeff_t cur;
    logic                    accept;
    logic                    scanning;
    logic                    nonzero;
    logic                    mag_one;
    logic                    is_t1;

    // only one block in flight, the encoder must also be free
    assign accept   = start_i && (state_q == cavlc_block_pkg::SCAN_IDLE) && !enc_busy_i;
    assign scanning = (state_q == cavlc_block_pkg::SCAN_RUN);

    assign cur     = blk_q[idx_q];
    assign nonzero = (cur != '0);
    assign mag_one = (cur == cavlc_block_pkg::coeff_t'(1)) ||
                     (cur == cavlc_block_pkg::coeff_t'(-1));
    // trailing ones stop for good once any level above magnitude one shows up
    assign is_t1   = mag_one && (t1_q < 2'd3) && !big_seen_q;

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            state_q    <= cavlc_block_pkg::SCAN_IDLE;
            idx_q      <= '0;
            load_q     <= 1'b0;
            total_q    <= '0;
            t1_q       <= '0;
            t1_signs_q <= '0;
            lvl_cnt_q  <= '0;
            big_seen_q <= 1'b0;
        end else begin
            load_q <= 1'b0;
            case (state_q)
                cavlc_block_pkg::SCAN_IDLE: begin
                    if (accept) begin
                        state_q    <= cavlc_block_pkg::SCAN_RUN;
                        idx_q      <= 4'(`CAVLC_BLOCK_N - 1);
                        total_q    <= '0;
                        t1_q       <= '0;
                        t1_signs_q <= '0;
                        lvl_cnt_q  <= '0;
                        big_seen_q <= 1'b0;
                    end
                end
                cavlc_block_pkg::SCAN_RUN: begin
                    if (nonzero) begin
                        total_q <= total_q + 5'd1;
                        if (is_t1) begin
                            t1_signs_q[t1_q] <= cur[`CAVLC_COEFF_W-1];
                            t1_q             <= t1_q + 2'd1;
                        end else begin
                            lvl_cnt_q <= lvl_cnt_q + 5'd1;
                        end
                        if (!mag_one) begin
                            big_seen_q <= 1'b1;
                        end
                    end
                    if (idx_q == 4'd0) begin
                        state_q <= cavlc_block_pkg::SCAN_DONE;
                        load_q  <= 1'b1;
                    end
                    idx_q <= idx_q - 4'd1;
                end
                default: begin
                    state_q <= cavlc_block_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q <= coeffs_i;
        end
        if (scanning && nonzero && !is_t1) begin
            levels_q[lvl_cnt_q[3:0]] <= cur;
        end
    end

    assign busy_o      = (state_q != cavlc_block_pkg::SCAN_IDLE) || enc_busy_i;
    assign load_o      = load_q;
    assign summary_o   = '{total_coeff: total_q, trailing_ones: t1_q, t1_signs: t1_signs_q};
    assign levels_o    = levels_q;
    assign level_cnt_o = lvl_cnt_q;

    // the index and the nonzero count never add up past the last position of the block
    a_idx_range: assert property (@(posedge clk) disable iff (enc_rst)
        scanning |-> (({1'b0, idx_q} + total_q) <= 5'(`CAVLC_BLOCK_N - 1)));

    a_load_in_done: assert property (@(posedge clk) disable iff (enc_rst)
        load_o |-> (state_q == cavlc_block_pkg::SCAN_DONE));

endmodule

/* hw/level_code_encoder.sv */
`timescale 1ns/1ps
`include "cavlc_settings.svh"

module level_code_encoder (
    input  logic                            clk,
    input  logic                            enc_rst,
    input  logic                            load_i,
    input  cavlc_block_pkg::block_summary_t summary_i,
    input  cavlc_block_pkg::level_list_t    levels_i,
    input  logic [4:0]                      level_cnt_i,
    output logic                            busy_o,
    output logic                            level_valid_o,
    output cavlc_code_pkg::level_codeword_t level_code_o,
    output logic                            done_o,
    output cavlc_block_pkg::block_summary_t summary_o,
    output logic [8:0]                      level_bits_o
);

    cavlc_code_pkg::enc_state_e      state_q;
    logic [3:0]                      idx_q;
    logic [2:0]                      sl_q;
    logic [8:0]                      bits_q;
    cavlc_block_pkg::block_summary_t summary_q;

    cavlc_block_pkg::coeff_t         level;
    logic signed [9:0]               level_w;
    logic [7:0]                      mag;
    logic [9:0]                      code;
    logic [9:0]                      shifted;
    logic [9:0]                      low_mask;
    logic [9:0]                      esc;
    logic [2:0]                      sl_min1;
    logic [2:0]                      sl_next;
    logic                            last;
    cavlc_code_pkg::level_codeword_t cw;

    always_comb begin
        level   = levels_i[idx_q];
        level_w = 10'(level);
        // abs of -128 still reads correctly as an unsigned 128
        mag     = level[`CAVLC_COEFF_W-1] ? 8'(-level) : 8'(level);

        if (level[`CAVLC_COEFF_W-1]) begin
            code = -(level_w <<< 1) - 10'sd1;
        end else begin
            code = (level_w <<< 1) - 10'sd2;
        end
        // the first level cannot be +-1 unless all three trailing ones were taken
        if (idx_q == 4'd0 && summary_q.trailing_ones < 2'd3) begin
            code = code - 10'd2;
        end

        shifted  = code >> sl_q;
        low_mask = ~({10{1'b1}} << sl_q);
        esc      = code - (10'd15 << sl_q) - ((sl_q == 3'd0) ? 10'd15 : 10'd0);

        if (shifted < 10'd14) begin
            cw.prefix     = shifted[4:0];
            cw.suffix     = 12'(code & low_mask);
            cw.suffix_len = 4'(sl_q);
        end else if (sl_q == 3'd0 && code < 10'd30) begin
            cw.prefix     = 5'd14;
            cw.suffix     = 12'(code - 10'd14);
            cw.suffix_len = 4'd4;
        end else if (sl_q != 3'd0 && shifted == 10'd14) begin
            cw.prefix     = 5'd14;
            cw.suffix     = 12'(code & low_mask);
            cw.suffix_len = 4'(sl_q);
        end else begin
            cw.prefix     = 5'd15;
            cw.suffix     = 12'(esc);
            cw.suffix_len = 4'(`CAVLC_ESC_SUFFIX_W);
        end

        // suffix length adapts to the magnitude just coded
        sl_min1 = (sl_q == 3'd0) ? 3'd1 : sl_q;
        sl_next = sl_min1;
        if (({2'b00, mag} > (10'd3 << (sl_min1 - 3'd1))) &&
            (sl_min1 < 3'(`CAVLC_MAX_SUFFIX))) begin
            sl_next = sl_min1 + 3'd1;
        end

        last = ({1'b0, idx_q} == (level_cnt_i - 5'd1));
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            state_q <= cavlc_code_pkg::ENC_IDLE;
            idx_q   <= '0;
            sl_q    <= '0;
            bits_q  <= '0;
        end else begin
            case (state_q)
                cavlc_code_pkg::ENC_IDLE: begin
                    if (load_i) begin
                        idx_q  <= '0;
                        bits_q <= '0;
                        if (summary_i.total_coeff > 5'd10 && summary_i.trailing_ones < 2'd3) begin
                            sl_q <= 3'd1;
                        end else begin
                            sl_q <= 3'd0;
                        end
                        if (level_cnt_i == 5'd0) begin
                            state_q <= cavlc_code_pkg::ENC_FINISH;
                        end else begin
                            state_q <= cavlc_code_pkg::ENC_RUN;
                        end
                    end
                end
                cavlc_code_pkg::ENC_RUN: begin
                    idx_q  <= idx_q + 4'd1;
                    sl_q   <= sl_next;
                    bits_q <= bits_q + {4'd0, cw.prefix} + 9'd1 + {5'd0, cw.suffix_len};
                    if (last) begin
                        state_q <= cavlc_code_pkg::ENC_FINISH;
                    end
                end
                default: begin
                    state_q <= cavlc_code_pkg::ENC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_i && state_q == cavlc_code_pkg::ENC_IDLE) begin
            summary_q <= summary_i;
        end
    end

    assign busy_o        = (state_q != cavlc_code_pkg::ENC_IDLE);
    assign level_valid_o = (state_q == cavlc_code_pkg::ENC_RUN);
    assign level_code_o  = cw;
    assign done_o        = (state_q == cavlc_code_pkg::ENC_FINISH);
    assign summary_o     = summary_q;
    assign level_bits_o  = bits_q;

    a_suffix_max: assert property (@(posedge clk) disable iff (enc_rst)
        sl_q <= 3'(`CAVLC_MAX_SUFFIX));

endmodule

/* hw/cavlc_level_top.sv */
`timescale 1ns/1ps
`include "cavlc_settings.svh"

module cavlc_level_top (
    input  logic                            clk,
    input  logic                            enc_rst,
    input  logic                            start_i,
    input  cavlc_block_pkg::coeff_block_t   coeffs_i,
    output logic                            busy_o,
    output logic                            level_valid_o,
    output cavlc_code_pkg::level_codeword_t level_code_o,
    output logic                            done_o,
    output cavlc_block_pkg::block_summary_t summary_o,
    output logic [8:0]                      level_bits_o
);

    logic                            enc_busy;
    logic                            load;
    cavlc_block_pkg::block_summary_t summary;
    cavlc_block_pkg::level_list_t    levels;
    logic [4:0]                      level_cnt;

    coeff_scanner u_scanner (
        .clk         (clk),
        .enc_rst     (enc_rst),
        .start_i     (start_i),
        .coeffs_i    (coeffs_i),
        .enc_busy_i  (enc_busy),
        .busy_o      (busy_o),
        .load_o      (load),
        .summary_o   (summary),
        .levels_o    (levels),
        .level_cnt_o (level_cnt)
    );

    level_code_encoder u_encoder (
        .clk           (clk),
        .enc_rst       (enc_rst),
        .load_i        (load),
        .summary_i     (summary),
        .levels_i      (levels),
        .level_cnt_i   (level_cnt),
        .busy_o        (enc_busy),
        .level_valid_o (level_valid_o),
        .level_code_o  (level_code_o),
        .done_o        (done_o),
        .summary_o     (summary_o),
        .level_bits_o  (level_bits_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic enc_rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // two rising edges see reset, release happens away from the active edge
    initial begin
        enc_rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        enc_rst = 1'b0;
    end

endmodule

/* tb/tb_cavlc_level.sv */
`timescale 1ns/1ps
`include "cavlc_settings.svh"

module tb_cavlc_level;

    localparam int N_DIRECTED = 14;
    localparam int N_ONES     = 8;
    localparam int N_SMALL    = 24;
    localparam int N_LARGE    = 24;
    localparam int NUM_BLOCKS = N_DIRECTED + N_ONES + N_SMALL + N_LARGE;
    // a block takes at most 18 + 16 cycles, a few more go to the start pulse
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * (18 + 16 + 4) + 100;

    logic                            clk;
    logic                            enc_rst;
    logic                            start_i;
    cavlc_block_pkg::coeff_block_t   coeffs_i;
    logic                            busy_o;
    logic                            level_valid_o;
    cavlc_code_pkg::level_codeword_t level_code_o;
    logic                            done_o;
    cavlc_block_pkg::block_summary_t summary_o;
    logic [8:0]                      level_bits_o;

    cavlc_code_pkg::level_codeword_t exp_cw[$];
    cavlc_block_pkg::block_summary_t exp_sum[$];
    logic [8:0]                      exp_bits[$];
    int                              exp_done_cyc[$];

    logic [31:0]                   lfsr_q;
    cavlc_block_pkg::coeff_block_t blk;
    int cyc;
    int sent;
    int blocks_done;
    int errors;
    int failures;
    int i;

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .enc_rst (enc_rst)
    );

    cavlc_level_top u_cavlc_level_top (
        .clk           (clk),
        .enc_rst       (enc_rst),
        .start_i       (start_i),
        .coeffs_i      (coeffs_i),
        .busy_o        (busy_o),
        .level_valid_o (level_valid_o),
        .level_code_o  (level_code_o),
        .done_o        (done_o),
        .summary_o     (summary_o),
        .level_bits_o  (level_bits_o)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // kind 0 gives only +-1, kind 1 small signed values, kind 2 full range
    function automatic cavlc_block_pkg::coeff_block_t random_block(input int kind);
        cavlc_block_pkg::coeff_block_t b;
        logic [7:0] t;
        int k;
        for (k = 0; k < `CAVLC_BLOCK_N; k++) begin
            b[k] = '0;
            if (kind == 0) begin
                t = take_bits(2);
                if (t == 8'd1) begin
                    b[k] = 8'sh01;
                end else if (t == 8'd2) begin
                    b[k] = 8'shff;
                end
            end else if (kind == 1) begin
                t = take_bits(2);
                if (t != 8'd0) begin
                    t = take_bits(4);
                    b[k] = {{4{t[3]}}, t[3:0]};
                end
            end else begin
                t = take_bits(1);
                if (t != 8'd0) begin
                    b[k] = take_bits(8);
                end
            end
        end
        return b;
    endfunction

    // expected codewords, summary and bit total of one block, queued in order
    function automatic int model_block(input cavlc_block_pkg::coeff_block_t b);
        cavlc_block_pkg::block_summary_t sum;
        cavlc_code_pkg::level_codeword_t cw;
        int lev[`CAVLC_BLOCK_N];
        int total;
        int t1;
        int nlev;
        int sl;
        int code;
        int mag;
        int val;
        int bits;
        int k;
        int prefix;
        int suffix;
        int slen;
        logic big;
        total = 0;
        t1 = 0;
        nlev = 0;
        bits = 0;
        big = 1'b0;
        sum = '0;
        for (k = `CAVLC_BLOCK_N - 1; k >= 0; k--) begin
            val = int'(b[k]);
            mag = (val < 0) ? -val : val;
            if (val != 0) begin
                total++;
                if (mag == 1 && t1 < 3 && !big) begin
                    sum.t1_signs[t1] = (val < 0);
                    t1++;
                end else begin
                    lev[nlev] = val;
                    nlev++;
                end
                if (mag != 1) begin
                    big = 1'b1;
                end
            end
        end
        sum.total_coeff   = 5'(total);
        sum.trailing_ones = 2'(t1);
        sl = (total > 10 && t1 < 3) ? 1 : 0;
        for (k = 0; k < nlev; k++) begin
            val  = lev[k];
            mag  = (val < 0) ? -val : val;
            code = (val > 0) ? 2 * val - 2 : -2 * val - 1;
            if (k == 0 && t1 < 3) begin
                code -= 2;
            end
            if ((code >> sl) < 14) begin
                prefix = code >> sl;
                suffix = code & ((1 << sl) - 1);
                slen   = sl;
            end else if (sl == 0 && code < 30) begin
                prefix = 14;
                suffix = code - 14;
                slen   = 4;
            end else if (sl != 0 && (code >> sl) == 14) begin
                prefix = 14;
                suffix = code & ((1 << sl) - 1);
                slen   = sl;
            end else begin
                prefix = 15;
                suffix = code - (15 << sl) - ((sl == 0) ? 15 : 0);
                slen   = `CAVLC_ESC_SUFFIX_W;
            end
            cw.prefix     = 5'(prefix);
            cw.suffix     = 12'(suffix);
            cw.suffix_len = 4'(slen);
            exp_cw.push_back(cw);
            bits += prefix + 1 + slen;
            if (sl == 0) begin
                sl = 1;
            end
            if (mag > (3 << (sl - 1)) && sl < `CAVLC_MAX_SUFFIX) begin
                sl++;
            end
        end
        exp_sum.push_back(sum);
        exp_bits.push_back(9'(bits));
        return nlev;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic send_block(input cavlc_block_pkg::coeff_block_t b);
        int n_lev;
        @(negedge clk);
        while (busy_o) begin
            @(negedge clk);
        end
        // the next rising edge takes the start and counts as cycle cyc + 1
        n_lev = model_block(b);
        exp_done_cyc.push_back(cyc + 1 + 18 + n_lev);
        coeffs_i = b;
        start_i  = 1'b1;
        @(negedge clk);
        start_i  = 1'b0;
        sent++;
    endtask

    // this pulse must be dropped by the DUT
    task automatic start_while_busy(input cavlc_block_pkg::coeff_block_t b);
        @(negedge clk);
        if (!busy_o) begin
            $display("busy_o was low while a block was still in flight");
            failures++;
        end else begin
            coeffs_i = b;
            start_i  = 1'b1;
            @(negedge clk);
            start_i  = 1'b0;
        end
    endtask

    // every codeword strobe and done pulse is matched against the queued expectations
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!enc_rst) begin
            if (level_valid_o) begin
                if (exp_cw.size() == 0) begin
                    $display("a codeword strobe arrived while no codeword was expected");
                    failures++;
                end else begin
                    check("level_code_o", {11'd0, level_code_o}, {11'd0, exp_cw.pop_front()});
                end
            end
            if (done_o) begin
                if (exp_sum.size() == 0) begin
                    $display("done_o pulsed with no block in flight");
                    failures++;
                end else begin
                    if (exp_cw.size() != 0) begin
                        $display("done_o arrived with %0d codewords still missing", exp_cw.size());
                        failures++;
                        exp_cw.delete();
                    end
                    check("summary_o", {22'd0, summary_o}, {22'd0, exp_sum.pop_front()});
                    check("level_bits_o", {23'd0, level_bits_o}, {23'd0, exp_bits.pop_front()});
                    check("done_o cycle", cyc, exp_done_cyc.pop_front());
                    blocks_done++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("the watchdog expired before all blocks were done");
        $display("Something failed");
        $finish;
    end

    initial begin
        start_i     = 1'b0;
        coeffs_i    = '0;
        lfsr_q      = 32'h7841;
        cyc         = 0;
        sent        = 0;
        blocks_done = 0;
        errors      = 0;
        failures    = 0;
        @(negedge clk);
        while (enc_rst) begin
            @(negedge clk);
        end

        // strobes are idle and the bit total is cleared right after reset
        check("busy_o", {31'd0, busy_o}, 32'd0);
        check("level_valid_o", {31'd0, level_valid_o}, 32'd0);
        check("done_o", {31'd0, done_o}, 32'd0);
        check("level_bits_o", {23'd0, level_bits_o}, 32'd0);

        send_block('0);

        // five ones, the last two of them go to the level list
        blk = '0;
        blk[15] = 8'sd1;
        blk[14] = -8'sd1;
        blk[12] = 8'sd1;
        blk[9]  = -8'sd1;
        blk[3]  = 8'sd1;
        send_block(blk);
        blk = '0;
        blk[15] = -8'sd1;
        blk[14] = 8'sd3;
        blk[13] = 8'sd1;
        send_block(blk);
        for (i = 0; i < N_ONES; i++) begin
            send_block(random_block(0));
        end

        // magnitudes that step the suffix length from 0 up to 6
        blk = '0;
        blk[15] = 8'sd4;
        blk[14] = -8'sd7;
        blk[13] = 8'sd13;
        blk[12] = -8'sd25;
        blk[11] = 8'sd49;
        blk[10] = -8'sd100;
        blk[9]  = 8'sd60;
        send_block(blk);
        for (i = 0; i < N_SMALL; i++) begin
            send_block(random_block(1));
        end

        // single levels at suffix length 0 around the escape limits
        blk = '0;
        blk[5] = 8'sd8;
        send_block(blk);
        blk[5] = 8'sd10;
        send_block(blk);
        blk[5] = 8'sd20;
        send_block(blk);
        blk[5] = 8'sd127;
        send_block(blk);
        blk[5] = -8'sd128;
        send_block(blk);
        blk = '0;
        blk[15] = 8'sd1;
        blk[14] = -8'sd1;
        blk[13] = 8'sd1;
        blk[12] = -8'sd9;
        send_block(blk);

        // full block, suffix length starts at 1 and the first level hits prefix 14
        blk = {8'sd16, -8'sd128, 8'sd127, -8'sd3, 8'sd1, -8'sd1, 8'sd50, -8'sd60,
               8'sd2, -8'sd2, 8'sd90, -8'sd90, 8'sd7, -8'sd7, 8'sd33, -8'sd33};
        send_block(blk);
        for (i = 0; i < N_LARGE; i++) begin
            send_block(random_block(2));
        end

        send_block(random_block(2));
        start_while_busy(random_block(2));
        send_block(random_block(1));

        while (blocks_done < sent) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (exp_sum.size() != 0 || exp_cw.size() != 0) begin
            $display("expected results were left over at the end of the run");
            failures++;
        end
        $display("blocks: %0d, mismatches: %0d, other failures: %0d",
                 blocks_done, errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/cavlc_block_pkg.sv
hw/cavlc_code_pkg.sv
hw/coeff_scanner.sv
hw/level_code_encoder.sv
hw/cavlc_level_top.sv
tb/tb_clock_gen.sv
tb/tb_cavlc_level.sv

/* Makefile */
VERILATOR = verilator
TOP       = tb_cavlc_level
FILELIST  = files.f
FLAGS     = --binary --timing --assert -j 0
BUILD_DIR = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass message is found in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
